/* bru_iq_pkg.sv */
/*
 * bru issue queue package
 * sizes, the branch unit opcode set and the layout of one queued op
 */

package bru_iq_pkg;

	// --------------------
	// sizes
	localparam int DISPATCH_WAYS = 4;
	localparam int IQ_ENTRIES = 8;
	localparam int LOG_IQ_ENTRIES = 3;
	localparam int LOG_PR_COUNT = 6;
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = 2;
	localparam int LOG_ROB_ENTRIES = 5;
	localparam int PRED_INFO_WIDTH = 8;

	// --------------------
	// opcodes
	// upper bit set for conditional branches
	typedef enum logic [3:0] {
		JALR  = 4'b0000,
		JAL   = 4'b0001,
		AUIPC = 4'b0010,
		LUI   = 4'b0011,
		BEQ   = 4'b1000,
		BNE   = 4'b1001,
		BLT   = 4'b1100,
		BGE   = 4'b1101,
		BLTU  = 4'b1110,
		BGEU  = 4'b1111
	} bru_op_t;

	// --------------------
	// one queued op
	typedef struct packed {
		bru_op_t op;
		logic [PRED_INFO_WIDTH-1:0] pred_info;
		logic is_link_ra;
		logic is_ret_ra;
		logic [31:0] pc;
		logic [31:0] pred_pc;
		logic [19:0] imm20;
		logic [LOG_PR_COUNT-1:0] A_pr;
		logic A_unneeded;
		logic A_ready;
		logic [LOG_PR_COUNT-1:0] B_pr;
		logic B_unneeded;
		logic B_ready;
		logic [LOG_PR_COUNT-1:0] dest_pr;
		logic [LOG_ROB_ENTRIES-1:0] rob_index;
	} bru_iq_entry_t;

endpackage

/* bru_iq_if.sv */
/*
 * bru issue queue write port
 * packed write slots from dispatch into the entry array, with the
 * free entry count going back the other way
 */

`timescale 1ns/10ps

interface bru_iq_if import bru_iq_pkg::*; ();

	// slots are filled from slot 0 upward
	logic [DISPATCH_WAYS-1:0] slot_valid;
	bru_iq_entry_t [DISPATCH_WAYS-1:0] slot_entry;

	// empty entries at the start of the cycle
	logic [LOG_IQ_ENTRIES:0] free_count;

	modport dispatch_mp (
		output slot_valid,
		output slot_entry,
		input free_count
	);

	modport entries_mp (
		input slot_valid,
		input slot_entry,
		output free_count
	);

endinterface

/* bru_iq_dispatch.sv */
/*
 * bru issue queue dispatch
 * acks attempting ways in way order against the free entry count and
 * packs the accepted valid ops into consecutive write slots
 */

`timescale 1ns/10ps

module bru_iq_dispatch import bru_iq_pkg::*; (
	input logic [DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_valid_by_way,
	input bru_op_t [DISPATCH_WAYS-1:0] dispatch_op_by_way,
	input logic [DISPATCH_WAYS-1:0][PRED_INFO_WIDTH-1:0] dispatch_pred_info_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_is_link_ra_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_is_ret_ra_by_way,
	input logic [DISPATCH_WAYS-1:0][31:0] dispatch_pc_by_way,
	input logic [DISPATCH_WAYS-1:0][31:0] dispatch_pred_pc_by_way,
	input logic [DISPATCH_WAYS-1:0][19:0] dispatch_imm20_by_way,
	input logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0] dispatch_A_pr_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_A_unneeded_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_A_ready_by_way,
	input logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0] dispatch_B_pr_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_B_unneeded_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_B_ready_by_way,
	input logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0] dispatch_dest_pr_by_way,
	input logic [DISPATCH_WAYS-1:0][LOG_ROB_ENTRIES-1:0] dispatch_rob_index_by_way,

	output logic [DISPATCH_WAYS-1:0] dispatch_ack_by_way,

	bru_iq_if.dispatch_mp wr
);

	// --------------------
	// acks
	always_comb begin
		int attempt_count;
		attempt_count = 0;
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			attempt_count = attempt_count + int'(dispatch_attempt_by_way[w]);
			// running count includes this way
			dispatch_ack_by_way[w] = dispatch_attempt_by_way[w]
				&& (attempt_count <= int'(wr.free_count));
		end
	end

	// --------------------
	// slot packing
	always_comb begin
		int slot_count;
		slot_count = 0;
		wr.slot_valid = '0;
		wr.slot_entry = '0;
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			// acked but invalid ways take no slot
			if (dispatch_ack_by_way[w] && dispatch_valid_by_way[w]) begin
				wr.slot_valid[slot_count] = 1'b1;
				wr.slot_entry[slot_count].op = dispatch_op_by_way[w];
				wr.slot_entry[slot_count].pred_info = dispatch_pred_info_by_way[w];
				wr.slot_entry[slot_count].is_link_ra = dispatch_is_link_ra_by_way[w];
				wr.slot_entry[slot_count].is_ret_ra = dispatch_is_ret_ra_by_way[w];
				wr.slot_entry[slot_count].pc = dispatch_pc_by_way[w];
				wr.slot_entry[slot_count].pred_pc = dispatch_pred_pc_by_way[w];
				wr.slot_entry[slot_count].imm20 = dispatch_imm20_by_way[w];
				wr.slot_entry[slot_count].A_pr = dispatch_A_pr_by_way[w];
				wr.slot_entry[slot_count].A_unneeded = dispatch_A_unneeded_by_way[w];
				wr.slot_entry[slot_count].A_ready = dispatch_A_ready_by_way[w];
				wr.slot_entry[slot_count].B_pr = dispatch_B_pr_by_way[w];
				wr.slot_entry[slot_count].B_unneeded = dispatch_B_unneeded_by_way[w];
				wr.slot_entry[slot_count].B_ready = dispatch_B_ready_by_way[w];
				wr.slot_entry[slot_count].dest_pr = dispatch_dest_pr_by_way[w];
				wr.slot_entry[slot_count].rob_index = dispatch_rob_index_by_way[w];
				slot_count = slot_count + 1;
			end
		end
	end

endmodule

/* bru_iq_entries.sv */
/*
 * bru issue queue entry array
 * age ordered shift queue, oldest at index 0, with operand wakeup
 * from the banked writeback bus
 */

`timescale 1ns/10ps

module bru_iq_entries import bru_iq_pkg::*; (
	input logic CLK,
	input logic nRST,

	bru_iq_if.entries_mp wr,

	input logic [PRF_BANK_COUNT-1:0] wb_valid_by_bank,
	input logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,

	input logic issue_fire,
	input logic [LOG_IQ_ENTRIES-1:0] issue_index,

	output logic [IQ_ENTRIES-1:0] entry_valid,
	output bru_iq_entry_t [IQ_ENTRIES-1:0] entries,
	output logic [IQ_ENTRIES-1:0] A_wake,
	output logic [IQ_ENTRIES-1:0] B_wake
);

	logic [LOG_IQ_ENTRIES:0] occupancy;
	logic [LOG_IQ_ENTRIES:0] remain;

	bru_iq_entry_t [IQ_ENTRIES-1:0] woken;
	logic [IQ_ENTRIES-1:0] valid_shift;
	bru_iq_entry_t [IQ_ENTRIES-1:0] entries_shift;
	logic [IQ_ENTRIES-1:0] valid_next;
	bru_iq_entry_t [IQ_ENTRIES-1:0] entries_next;

	// tag match against the bus, bank picked by the tag's low bits
	function automatic logic wb_hit(
		input logic [LOG_PR_COUNT-1:0] pr,
		input logic [PRF_BANK_COUNT-1:0] valid_by_bank,
		input logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] upper_by_bank
	);
		logic [LOG_PRF_BANK_COUNT-1:0] bank;
		bank = pr[LOG_PRF_BANK_COUNT-1:0];
		return valid_by_bank[bank]
			&& (upper_by_bank[bank] == pr[LOG_PR_COUNT-1:LOG_PRF_BANK_COUNT]);
	endfunction

	// --------------------
	// occupancy
	always_comb begin
		occupancy = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			occupancy = occupancy + {{LOG_IQ_ENTRIES{1'b0}}, entry_valid[i]};
		end
	end

	assign wr.free_count = (LOG_IQ_ENTRIES+1)'(IQ_ENTRIES) - occupancy;
	assign remain = occupancy - {{LOG_IQ_ENTRIES{1'b0}}, issue_fire};

	// --------------------
	// wakeup of waiting operands
	always_comb begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			A_wake[i] = entry_valid[i] && !entries[i].A_ready && !entries[i].A_unneeded
				&& wb_hit(entries[i].A_pr, wb_valid_by_bank, wb_upper_pr_by_bank);
			B_wake[i] = entry_valid[i] && !entries[i].B_ready && !entries[i].B_unneeded
				&& wb_hit(entries[i].B_pr, wb_valid_by_bank, wb_upper_pr_by_bank);
			woken[i] = entries[i];
			woken[i].A_ready = entries[i].A_ready | A_wake[i];
			woken[i].B_ready = entries[i].B_ready | B_wake[i];
		end
	end

	// --------------------
	// drop the issued entry, younger ones move down by one
	always_comb begin
		for (int i = 0; i < IQ_ENTRIES-1; i++) begin
			if (issue_fire && (i >= int'(issue_index))) begin
				valid_shift[i] = entry_valid[i+1];
				entries_shift[i] = woken[i+1];
			end
			else begin
				valid_shift[i] = entry_valid[i];
				entries_shift[i] = woken[i];
			end
		end
		// top entry always leaves on issue
		valid_shift[IQ_ENTRIES-1] = entry_valid[IQ_ENTRIES-1] && !issue_fire;
		entries_shift[IQ_ENTRIES-1] = woken[IQ_ENTRIES-1];
	end

	// --------------------
	// append write slots after the last remaining entry
	always_comb begin
		bru_iq_entry_t incoming;
		valid_next = valid_shift;
		entries_next = entries_shift;
		for (int s = 0; s < DISPATCH_WAYS; s++) begin
			incoming = wr.slot_entry[s];
			// writeback in the dispatch cycle counts as ready
			incoming.A_ready |= wb_hit(incoming.A_pr, wb_valid_by_bank, wb_upper_pr_by_bank);
			incoming.B_ready |= wb_hit(incoming.B_pr, wb_valid_by_bank, wb_upper_pr_by_bank);
			for (int p = 0; p < IQ_ENTRIES; p++) begin
				if (wr.slot_valid[s] && (p == int'(remain) + s)) begin
					valid_next[p] = 1'b1;
					entries_next[p] = incoming;
				end
			end
		end
	end

	// --------------------
	// state
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			entry_valid <= '0;
		end
		else begin
			entry_valid <= valid_next;
		end
	end

	always_ff @(posedge CLK) begin
		entries <= entries_next;
	end

endmodule

/* bru_iq_select.sv */
/*
 * bru issue queue select
 * oldest ready entry wins the issue port and the PRF read port
 */

`timescale 1ns/10ps

module bru_iq_select import bru_iq_pkg::*; (
	input logic [IQ_ENTRIES-1:0] entry_valid,
	input bru_iq_entry_t [IQ_ENTRIES-1:0] entries,
	input logic [IQ_ENTRIES-1:0] A_wake,
	input logic [IQ_ENTRIES-1:0] B_wake,
	input logic pipeline_ready,

	output logic issue_fire,
	output logic [LOG_IQ_ENTRIES-1:0] issue_index,

	output logic issue_valid,
	output bru_op_t issue_op,
	output logic [PRED_INFO_WIDTH-1:0] issue_pred_info,
	output logic issue_is_link_ra,
	output logic issue_is_ret_ra,
	output logic [31:0] issue_pc,
	output logic [31:0] issue_pred_pc,
	output logic [19:0] issue_imm20,
	output logic issue_A_unneeded,
	output logic issue_A_forward,
	output logic [LOG_PRF_BANK_COUNT-1:0] issue_A_bank,
	output logic issue_B_unneeded,
	output logic issue_B_forward,
	output logic [LOG_PRF_BANK_COUNT-1:0] issue_B_bank,
	output logic [LOG_PR_COUNT-1:0] issue_dest_pr,
	output logic [LOG_ROB_ENTRIES-1:0] issue_rob_index,

	output logic prf_req_A_valid,
	output logic [LOG_PR_COUNT-1:0] prf_req_A_pr,
	output logic prf_req_B_valid,
	output logic [LOG_PR_COUNT-1:0] prf_req_B_pr
);

	logic [IQ_ENTRIES-1:0] eligible;
	bru_iq_entry_t sel;

	// operands unneeded, already ready or waking right now
	always_comb begin
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			eligible[i] = entry_valid[i]
				&& (entries[i].A_unneeded || entries[i].A_ready || A_wake[i])
				&& (entries[i].B_unneeded || entries[i].B_ready || B_wake[i]);
		end
	end

	// lowest index wins, scan down so it is written last
	always_comb begin
		issue_index = '0;
		for (int i = IQ_ENTRIES-1; i >= 0; i--) begin
			if (eligible[i]) begin
				issue_index = LOG_IQ_ENTRIES'(i);
			end
		end
	end

	assign issue_fire = pipeline_ready && (|eligible);
	assign sel = entries[issue_index];

	// --------------------
	// issue fields
	assign issue_valid = issue_fire;
	assign issue_op = sel.op;
	assign issue_pred_info = sel.pred_info;
	assign issue_is_link_ra = sel.is_link_ra;
	assign issue_is_ret_ra = sel.is_ret_ra;
	assign issue_pc = sel.pc;
	assign issue_pred_pc = sel.pred_pc;
	assign issue_imm20 = sel.imm20;
	assign issue_A_unneeded = sel.A_unneeded;
	assign issue_A_forward = A_wake[issue_index];
	assign issue_A_bank = sel.A_pr[LOG_PRF_BANK_COUNT-1:0];
	assign issue_B_unneeded = sel.B_unneeded;
	assign issue_B_forward = B_wake[issue_index];
	assign issue_B_bank = sel.B_pr[LOG_PRF_BANK_COUNT-1:0];
	assign issue_dest_pr = sel.dest_pr;
	assign issue_rob_index = sel.rob_index;

	// --------------------
	// PRF reads, forwarded operands come off the bypass instead
	assign prf_req_A_valid = issue_fire && !sel.A_unneeded && !A_wake[issue_index];
	assign prf_req_A_pr = sel.A_pr;
	assign prf_req_B_valid = issue_fire && !sel.B_unneeded && !B_wake[issue_index];
	assign prf_req_B_pr = sel.B_pr;

endmodule

/* bru_iq_top.sv */
/*
 * bru issue queue
 * eight entry branch unit queue, four way dispatch, single issue
 */

`timescale 1ns/10ps

module bru_iq_top import bru_iq_pkg::*; (
	input logic CLK,
	input logic nRST,

	// dispatch by way
	input logic [DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_valid_by_way,
	input bru_op_t [DISPATCH_WAYS-1:0] dispatch_op_by_way,
	input logic [DISPATCH_WAYS-1:0][PRED_INFO_WIDTH-1:0] dispatch_pred_info_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_is_link_ra_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_is_ret_ra_by_way,
	input logic [DISPATCH_WAYS-1:0][31:0] dispatch_pc_by_way,
	input logic [DISPATCH_WAYS-1:0][31:0] dispatch_pred_pc_by_way,
	input logic [DISPATCH_WAYS-1:0][19:0] dispatch_imm20_by_way,
	input logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0] dispatch_A_pr_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_A_unneeded_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_A_ready_by_way,
	input logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0] dispatch_B_pr_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_B_unneeded_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_B_ready_by_way,
	input logic [DISPATCH_WAYS-1:0][LOG_PR_COUNT-1:0] dispatch_dest_pr_by_way,
	input logic [DISPATCH_WAYS-1:0][LOG_ROB_ENTRIES-1:0] dispatch_rob_index_by_way,
	output logic [DISPATCH_WAYS-1:0] dispatch_ack_by_way,

	// back-pressure from the BRU pipeline
	input logic pipeline_ready,

	// writeback bus
	input logic [PRF_BANK_COUNT-1:0] wb_valid_by_bank,
	input logic [PRF_BANK_COUNT-1:0][LOG_PR_COUNT-LOG_PRF_BANK_COUNT-1:0] wb_upper_pr_by_bank,

	// issue to the BRU pipeline
	output logic issue_valid,
	output bru_op_t issue_op,
	output logic [PRED_INFO_WIDTH-1:0] issue_pred_info,
	output logic issue_is_link_ra,
	output logic issue_is_ret_ra,
	output logic [31:0] issue_pc,
	output logic [31:0] issue_pred_pc,
	output logic [19:0] issue_imm20,
	output logic issue_A_unneeded,
	output logic issue_A_forward,
	output logic [LOG_PRF_BANK_COUNT-1:0] issue_A_bank,
	output logic issue_B_unneeded,
	output logic issue_B_forward,
	output logic [LOG_PRF_BANK_COUNT-1:0] issue_B_bank,
	output logic [LOG_PR_COUNT-1:0] issue_dest_pr,
	output logic [LOG_ROB_ENTRIES-1:0] issue_rob_index,

	// PRF read requests
	output logic prf_req_A_valid,
	output logic [LOG_PR_COUNT-1:0] prf_req_A_pr,
	output logic prf_req_B_valid,
	output logic [LOG_PR_COUNT-1:0] prf_req_B_pr
);

	logic [IQ_ENTRIES-1:0] entry_valid;
	bru_iq_entry_t [IQ_ENTRIES-1:0] entries;
	logic [IQ_ENTRIES-1:0] A_wake;
	logic [IQ_ENTRIES-1:0] B_wake;
	logic issue_fire;
	logic [LOG_IQ_ENTRIES-1:0] issue_index;

	bru_iq_if wr_if ();

	// --------------------
	// blocks
	bru_iq_dispatch i_dispatch (
		.dispatch_attempt_by_way(dispatch_attempt_by_way),
		.dispatch_valid_by_way(dispatch_valid_by_way),
		.dispatch_op_by_way(dispatch_op_by_way),
		.dispatch_pred_info_by_way(dispatch_pred_info_by_way),
		.dispatch_is_link_ra_by_way(dispatch_is_link_ra_by_way),
		.dispatch_is_ret_ra_by_way(dispatch_is_ret_ra_by_way),
		.dispatch_pc_by_way(dispatch_pc_by_way),
		.dispatch_pred_pc_by_way(dispatch_pred_pc_by_way),
		.dispatch_imm20_by_way(dispatch_imm20_by_way),
		.dispatch_A_pr_by_way(dispatch_A_pr_by_way),
		.dispatch_A_unneeded_by_way(dispatch_A_unneeded_by_way),
		.dispatch_A_ready_by_way(dispatch_A_ready_by_way),
		.dispatch_B_pr_by_way(dispatch_B_pr_by_way),
		.dispatch_B_unneeded_by_way(dispatch_B_unneeded_by_way),
		.dispatch_B_ready_by_way(dispatch_B_ready_by_way),
		.dispatch_dest_pr_by_way(dispatch_dest_pr_by_way),
		.dispatch_rob_index_by_way(dispatch_rob_index_by_way),
		.dispatch_ack_by_way(dispatch_ack_by_way),
		.wr(wr_if.dispatch_mp)
	);

	bru_iq_entries i_entries (
		.CLK(CLK),
		.nRST(nRST),
		.wr(wr_if.entries_mp),
		.wb_valid_by_bank(wb_valid_by_bank),
		.wb_upper_pr_by_bank(wb_upper_pr_by_bank),
		.issue_fire(issue_fire),
		.issue_index(issue_index),
		.entry_valid(entry_valid),
		.entries(entries),
		.A_wake(A_wake),
		.B_wake(B_wake)
	);

	bru_iq_select i_select (
		.entry_valid(entry_valid),
		.entries(entries),
		.A_wake(A_wake),
		.B_wake(B_wake),
		.pipeline_ready(pipeline_ready),
		.issue_fire(issue_fire),
		.issue_index(issue_index),
		.issue_valid(issue_valid),
		.issue_op(issue_op),
		.issue_pred_info(issue_pred_info),
		.issue_is_link_ra(issue_is_link_ra),
		.issue_is_ret_ra(issue_is_ret_ra),
		.issue_pc(issue_pc),
		.issue_pred_pc(issue_pred_pc),
		.issue_imm20(issue_imm20),
		.issue_A_unneeded(issue_A_unneeded),
		.issue_A_forward(issue_A_forward),
		.issue_A_bank(issue_A_bank),
		.issue_B_unneeded(issue_B_unneeded),
		.issue_B_forward(issue_B_forward),
		.issue_B_bank(issue_B_bank),
		.issue_dest_pr(issue_dest_pr),
		.issue_rob_index(issue_rob_index),
		.prf_req_A_valid(prf_req_A_valid),
		.prf_req_A_pr(prf_req_A_pr),
		.prf_req_B_valid(prf_req_B_valid),
		.prf_req_B_pr(prf_req_B_pr)
	);

endmodule

/* bru_iq_props.sv */
/*
 * bru issue queue properties
 * issue, ack and PRF request rules at the top level ports
 */

`timescale 1ns/10ps

module bru_iq_props import bru_iq_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic [DISPATCH_WAYS-1:0] dispatch_attempt_by_way,
	input logic [DISPATCH_WAYS-1:0] dispatch_ack_by_way,
	input logic pipeline_ready,
	input logic issue_valid,
	input logic issue_A_unneeded,
	input logic issue_A_forward,
	input logic issue_B_unneeded,
	input logic issue_B_forward,
	input logic prf_req_A_valid,
	input logic prf_req_B_valid
);

	// acked ways form a run from way 0 among the attempting ways
	function automatic logic ack_run(logic [DISPATCH_WAYS-1:0] att, logic [DISPATCH_WAYS-1:0] ack);
		logic gap;
		gap = 1'b0;
		for (int w = 0; w < DISPATCH_WAYS; w++) begin
			if (ack[w] && (!att[w] || gap))
				return 1'b0;
			if (att[w] && !ack[w])
				gap = 1'b1;
		end
		return 1'b1;
	endfunction

	a_issue_ready: assert property (@(posedge CLK) disable iff (!nRST)
		issue_valid |-> pipeline_ready) else $error("issue without pipeline_ready");

	a_ack_run: assert property (@(posedge CLK) disable iff (!nRST)
		ack_run(dispatch_attempt_by_way, dispatch_ack_by_way))
		else $error("ack vector is not a run from way 0");

	a_reset_quiet: assert property (@(posedge CLK)
		!nRST |-> (dispatch_ack_by_way == '0) && !issue_valid)
		else $error("ack or issue during reset");

	a_prf_a: assert property (@(posedge CLK) disable iff (!nRST)
		prf_req_A_valid |-> issue_valid && !issue_A_unneeded && !issue_A_forward)
		else $error("bad PRF request on operand A");

	a_prf_b: assert property (@(posedge CLK) disable iff (!nRST)
		prf_req_B_valid |-> issue_valid && !issue_B_unneeded && !issue_B_forward)
		else $error("bad PRF request on operand B");

endmodule

bind bru_iq_top bru_iq_props i_props (.*);

/* tb_bru_iq.sv */
/*
 * bru issue queue testbench
 * table of per-cycle stimulus checked against a reference queue model
 */

`timescale 1ns/10ps

module tb_bru_iq;
	import bru_iq_pkg::*;

	typedef struct packed {
		logic [7:0] test;
		logic [3:0] attempt, valid, a_rdy, b_rdy, a_unn, b_unn;
		logic [5:0] a_base, b_base;
		logic [3:0] wb_v;
		logic [15:0] wb_up;
		logic pready;
	} row_t;

	logic CLK, nRST, pipeline_ready;
	logic [3:0] dispatch_attempt_by_way, dispatch_valid_by_way, dispatch_ack_by_way;
	bru_op_t [3:0] dispatch_op_by_way;
	logic [3:0][7:0] dispatch_pred_info_by_way;
	logic [3:0] dispatch_is_link_ra_by_way, dispatch_is_ret_ra_by_way;
	logic [3:0][31:0] dispatch_pc_by_way, dispatch_pred_pc_by_way;
	logic [3:0][19:0] dispatch_imm20_by_way;
	logic [3:0][5:0] dispatch_A_pr_by_way, dispatch_B_pr_by_way, dispatch_dest_pr_by_way;
	logic [3:0] dispatch_A_unneeded_by_way, dispatch_A_ready_by_way;
	logic [3:0] dispatch_B_unneeded_by_way, dispatch_B_ready_by_way;
	logic [3:0][4:0] dispatch_rob_index_by_way;
	logic [3:0] wb_valid_by_bank;
	logic [3:0][3:0] wb_upper_pr_by_bank;
	logic issue_valid, issue_is_link_ra, issue_is_ret_ra;
	bru_op_t issue_op;
	logic [7:0] issue_pred_info;
	logic [31:0] issue_pc, issue_pred_pc;
	logic [19:0] issue_imm20;
	logic issue_A_unneeded, issue_A_forward, issue_B_unneeded, issue_B_forward;
	logic [1:0] issue_A_bank, issue_B_bank;
	logic [5:0] issue_dest_pr, prf_req_A_pr, prf_req_B_pr;
	logic [4:0] issue_rob_index;
	logic prf_req_A_valid, prf_req_B_valid;

	bru_iq_top i_bru_iq_top (.*);

	row_t rows[$];
	bru_iq_entry_t model_q[$];
	bru_iq_entry_t drv[4];
	bru_op_t op_list[10] = '{JALR, JAL, AUIPC, LUI, BEQ, BNE, BLT, BGE, BLTU, BGEU};
	logic [31:0] seed = 32'd59;
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// a tag is announced when its bank strobes with the matching upper part
	function automatic logic wb_match(logic [5:0] tag);
		for (int k = 0; k < 4; k++) begin
			if (wb_valid_by_bank[k] && {wb_upper_pr_by_bank[k], 2'(k)} == tag)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic compare_field(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_ack(logic [DISPATCH_WAYS-1:0] exp);
		compare_field("dispatch_ack_by_way", 32'(exp), 32'(dispatch_ack_by_way));
	endtask

	task automatic check_issue(bru_iq_entry_t e, logic a_fwd, logic b_fwd);
		compare_field("issue_op", 32'(e.op), 32'(issue_op));
		compare_field("issue_pred_info", 32'(e.pred_info), 32'(issue_pred_info));
		compare_field("issue_is_link_ra", 32'(e.is_link_ra), 32'(issue_is_link_ra));
		compare_field("issue_is_ret_ra", 32'(e.is_ret_ra), 32'(issue_is_ret_ra));
		compare_field("issue_pc", e.pc, issue_pc);
		compare_field("issue_pred_pc", e.pred_pc, issue_pred_pc);
		compare_field("issue_imm20", 32'(e.imm20), 32'(issue_imm20));
		compare_field("issue_A_unneeded", 32'(e.A_unneeded), 32'(issue_A_unneeded));
		compare_field("issue_A_forward", 32'(a_fwd), 32'(issue_A_forward));
		compare_field("issue_A_bank", 32'(e.A_pr[1:0]), 32'(issue_A_bank));
		compare_field("issue_B_unneeded", 32'(e.B_unneeded), 32'(issue_B_unneeded));
		compare_field("issue_B_forward", 32'(b_fwd), 32'(issue_B_forward));
		compare_field("issue_B_bank", 32'(e.B_pr[1:0]), 32'(issue_B_bank));
		compare_field("issue_dest_pr", 32'(e.dest_pr), 32'(issue_dest_pr));
		compare_field("issue_rob_index", 32'(e.rob_index), 32'(issue_rob_index));
	endtask

	task automatic check_prf_req(string name, logic exp_v, logic [LOG_PR_COUNT-1:0] exp_pr,
			logic act_v, logic [LOG_PR_COUNT-1:0] act_pr);
		compare_field({name, "_valid"}, 32'(exp_v), 32'(act_v));
		if (exp_v)
			compare_field({name, "_pr"}, 32'(exp_pr), 32'(act_pr));
	endtask

	task automatic add_row(int t, logic [3:0] att, val, ardy, brdy, aunn, bunn,
			logic [5:0] ab, bb, logic [3:0] wbv, logic [15:0] wbu, logic pr);
		rows.push_back({8'(t), att, val, ardy, brdy, aunn, bunn, ab, bb, wbv, wbu, pr});
	endtask

	// drive one row on the falling edge, then check and advance the model
	task automatic step_cycle(row_t r);
		int free;
		int cnt;
		int sel;
		logic [3:0] exp_ack;
		logic aw[$];
		logic bw[$];
		bru_iq_entry_t e;
		@(negedge CLK);
		for (int w = 0; w < 4; w++) begin
			drv[w] = '{op: op_list[lcg_next() % 10], pred_info: 8'(lcg_next()),
				is_link_ra: 1'(lcg_next() >> 7), is_ret_ra: 1'(lcg_next() >> 9),
				pc: lcg_next(), pred_pc: lcg_next(), imm20: 20'(lcg_next()),
				A_pr: r.a_base + 6'(w), A_unneeded: r.a_unn[w], A_ready: r.a_rdy[w],
				B_pr: r.b_base + 6'(w), B_unneeded: r.b_unn[w], B_ready: r.b_rdy[w],
				dest_pr: 6'(lcg_next()), rob_index: 5'(lcg_next())};
			dispatch_op_by_way[w] = drv[w].op;
			dispatch_pred_info_by_way[w] = drv[w].pred_info;
			dispatch_is_link_ra_by_way[w] = drv[w].is_link_ra;
			dispatch_is_ret_ra_by_way[w] = drv[w].is_ret_ra;
			dispatch_pc_by_way[w] = drv[w].pc;
			dispatch_pred_pc_by_way[w] = drv[w].pred_pc;
			dispatch_imm20_by_way[w] = drv[w].imm20;
			dispatch_A_pr_by_way[w] = drv[w].A_pr;
			dispatch_A_unneeded_by_way[w] = drv[w].A_unneeded;
			dispatch_A_ready_by_way[w] = drv[w].A_ready;
			dispatch_B_pr_by_way[w] = drv[w].B_pr;
			dispatch_B_unneeded_by_way[w] = drv[w].B_unneeded;
			dispatch_B_ready_by_way[w] = drv[w].B_ready;
			dispatch_dest_pr_by_way[w] = drv[w].dest_pr;
			dispatch_rob_index_by_way[w] = drv[w].rob_index;
		end
		dispatch_attempt_by_way = r.attempt;
		dispatch_valid_by_way = r.valid;
		wb_valid_by_bank = r.wb_v;
		wb_upper_pr_by_bank = r.wb_up;
		pipeline_ready = r.pready;
		#1;
		// reference acks in way order against the free count
		free = 8 - model_q.size();
		cnt = 0;
		for (int w = 0; w < 4; w++) begin
			cnt += int'(r.attempt[w]);
			exp_ack[w] = r.attempt[w] && (cnt <= free);
		end
		check_ack(exp_ack);
		sel = -1;
		foreach (model_q[i]) begin
			aw.push_back(!model_q[i].A_ready && !model_q[i].A_unneeded
				&& wb_match(model_q[i].A_pr));
			bw.push_back(!model_q[i].B_ready && !model_q[i].B_unneeded
				&& wb_match(model_q[i].B_pr));
			if (sel < 0 && r.pready
					&& (model_q[i].A_unneeded || model_q[i].A_ready || aw[i])
					&& (model_q[i].B_unneeded || model_q[i].B_ready || bw[i]))
				sel = i;
		end
		compare_field("issue_valid", 32'(sel >= 0), 32'(issue_valid));
		if (sel >= 0) begin
			e = model_q[sel];
			check_issue(e, aw[sel], bw[sel]);
			check_prf_req("prf_req_A", !e.A_unneeded && !aw[sel], e.A_pr,
				prf_req_A_valid, prf_req_A_pr);
			check_prf_req("prf_req_B", !e.B_unneeded && !bw[sel], e.B_pr,
				prf_req_B_valid, prf_req_B_pr);
		end
		else begin
			check_prf_req("prf_req_A", 1'b0, 6'd0, prf_req_A_valid, prf_req_A_pr);
			check_prf_req("prf_req_B", 1'b0, 6'd0, prf_req_B_valid, prf_req_B_pr);
		end
		foreach (model_q[i]) begin
			model_q[i].A_ready |= aw[i];
			model_q[i].B_ready |= bw[i];
		end
		if (sel >= 0)
			model_q.delete(sel);
		for (int w = 0; w < 4; w++) begin
			if (exp_ack[w] && r.valid[w]) begin
				e = drv[w];
				e.A_ready |= wb_match(e.A_pr);
				e.B_ready |= wb_match(e.B_pr);
				model_q.push_back(e);
			end
		end
	endtask

	task automatic finish_test(int t);
		tests_run++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d done with %0d errors", t, test_errors);
		test_errors = 0;
	endtask

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// watchdog
	initial begin
		#20000;
		$display("simulation ran past its time limit");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		row_t idle;
		int guard;
		nRST = 1'b0;
		pipeline_ready = 1'b0;
		dispatch_attempt_by_way = '0;
		dispatch_valid_by_way = '0;
		dispatch_op_by_way = '{default: JALR};
		dispatch_pred_info_by_way = '0;
		dispatch_is_link_ra_by_way = '0;
		dispatch_is_ret_ra_by_way = '0;
		dispatch_pc_by_way = '0;
		dispatch_pred_pc_by_way = '0;
		dispatch_imm20_by_way = '0;
		dispatch_A_pr_by_way = '0;
		dispatch_A_unneeded_by_way = '0;
		dispatch_A_ready_by_way = '0;
		dispatch_B_pr_by_way = '0;
		dispatch_B_unneeded_by_way = '0;
		dispatch_B_ready_by_way = '0;
		dispatch_dest_pr_by_way = '0;
		dispatch_rob_index_by_way = '0;
		wb_valid_by_bank = '0;
		wb_upper_pr_by_bank = '0;

		// --------------------
		// reset with outputs held low
		repeat (8) begin
			@(negedge CLK);
			check_ack(4'b0);
			compare_field("issue_valid", 32'd0, 32'(issue_valid));
			check_prf_req("prf_req_A", 1'b0, 6'd0, prf_req_A_valid, prf_req_A_pr);
			check_prf_req("prf_req_B", 1'b0, 6'd0, prf_req_B_valid, prf_req_B_pr);
		end
		nRST = 1'b1;
		idle = '0;
		step_cycle(idle);
		finish_test(0);

		// in-order issue of ready ops
		add_row(1, 4'hF, 4'hF, 4'hF, 4'hF, 0, 0, 0, 4, 0, 0, 1);
		repeat (4) add_row(1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		// partial and full acks and an acked invalid way
		add_row(2, 4'hF, 4'hF, 4'hF, 4'hF, 0, 0, 8, 12, 0, 0, 0);
		add_row(2, 4'hF, 4'hF, 4'hF, 4'hF, 0, 0, 16, 20, 0, 0, 0);
		add_row(2, 4'hF, 4'hF, 4'hF, 4'hF, 0, 0, 24, 28, 0, 0, 0);
		add_row(2, 4'hF, 4'hF, 4'hF, 4'hF, 0, 0, 24, 28, 0, 0, 1);
		add_row(2, 4'hF, 4'hB, 4'hF, 4'hF, 0, 0, 32, 36, 0, 0, 0);
		repeat (3) add_row(2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(2, 4'hF, 4'hD, 4'hF, 4'hF, 0, 0, 40, 44, 0, 0, 1);
		repeat (7) add_row(2, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		// wakeup, forwarding and PRF requests
		add_row(3, 4'h3, 4'h3, 4'h0, 4'h3, 0, 0, 20, 48, 0, 0, 1);
		add_row(3, 0, 0, 0, 0, 0, 0, 0, 0, 4'h1, 16'h0005, 1);
		add_row(3, 0, 0, 0, 0, 0, 0, 0, 0, 4'h2, 16'h0050, 0);
		add_row(3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(3, 4'h1, 4'h1, 4'h0, 4'h1, 0, 0, 30, 50, 4'h4, 16'h0700, 1);
		add_row(3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(3, 4'h1, 4'h1, 4'h1, 4'h0, 0, 0, 52, 35, 0, 0, 1);
		add_row(3, 0, 0, 0, 0, 0, 0, 0, 0, 4'h8, 16'h8000, 1);
		// unneeded operands
		add_row(4, 4'h3, 4'h3, 0, 0, 4'h3, 4'h3, 0, 0, 0, 0, 1);
		repeat (2) add_row(4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		// back-pressure and a younger ready op passing an older one
		add_row(5, 4'h7, 4'h7, 4'h6, 4'h7, 0, 0, 40, 56, 0, 0, 0);
		repeat (2) add_row(5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);
		add_row(5, 0, 0, 0, 0, 0, 0, 0, 0, 4'h1, 16'h000A, 1);

		foreach (rows[i]) begin
			step_cycle(rows[i]);
			if (i == rows.size() - 1 || rows[i+1].test != rows[i].test)
				finish_test(int'(rows[i].test));
		end

		// drain whatever is left
		idle = '0;
		idle.pready = 1'b1;
		guard = 0;
		while (model_q.size() > 0 && guard < 40) begin
			step_cycle(idle);
			guard++;
		end
		if (model_q.size() > 0) begin
			$display("timeout: queue did not drain within 40 cycles");
			errors++;
			test_errors++;
		end
		finish_test(6);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end
		else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* flist.f */
bru_iq_pkg.sv
bru_iq_if.sv
bru_iq_dispatch.sv
bru_iq_entries.sv
bru_iq_select.sv
bru_iq_top.sv
bru_iq_props.sv
tb_bru_iq.sv

/* run.sh */
#!/bin/sh
# compile and run the bru issue queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_bru_iq -o sim_bru_iq
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

out=$(./obj_dir/sim_bru_iq)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
